/* filelist.f */
src/rob_pkg.sv
src/dispatch_ctrl.sv
src/reorder_buffer.sv
src/alu_unit.sv
src/mul_unit.sv
src/div_unit.sv
src/exec_backend.sv
test/backend_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the reorder-buffer back end testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module backend_tb \
    -f filelist.f \
    -o backend_sim

./obj_dir/backend_sim | tee sim.log

if grep -qx "Test OK" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

/* src/alu_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module alu_unit import rob_pkg::*; (
    input  wire       clk,
    input  wire       rst,
    input  wire       req_valid,
    input  unit_req_t req,
    output wb_t       wb
);

    data_t    result;
    logic     valid_q;
    rob_tag_t tag_q;
    data_t    value_q;

    always_comb begin
        case (req.op)
            OP_ADD:  result = req.src_a + req.src_b;
            OP_SUB:  result = req.src_a - req.src_b;
            OP_AND:  result = req.src_a & req.src_b;
            OP_OR:   result = req.src_a | req.src_b;
            OP_XOR:  result = req.src_a ^ req.src_b;
            default: result = '0;             // MUL and DIV never steered here
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= req_valid;             // Result one cycle after issue
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            tag_q   <= req.tag;
            value_q <= result;
        end
    end

    assign wb = '{valid: valid_q, tag: tag_q, value: value_q};

endmodule

`default_nettype wire

/* src/dispatch_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module dispatch_ctrl import rob_pkg::*; (
    input  wire       clk,
    input  wire       rst,
    input  wire       disp_req,
    input  issue_t    issue,
    output logic      disp_ack,
    input  wire       rob_full,
    input  rob_tag_t  next_tag,
    input  wire       div_busy,
    output logic      alloc,
    output reg_idx_t  alloc_dest,
    output logic      alloc_reg_write,
    output unit_req_t alu_req,
    output logic      alu_valid,
    output unit_req_t mul_req,
    output logic      mul_valid,
    output unit_req_t div_req,
    output logic      div_valid
);

    disp_state_e state;
    logic        is_mul;
    logic        is_div;
    logic        res_free;
    logic        accept;
    unit_req_t   req_word;

    assign is_mul   = (issue.op == OP_MUL);
    assign is_div   = (issue.op == OP_DIV);
    assign res_free = !rob_full && !(is_div && div_busy);  // Divider is the only blocking unit
    assign accept   = (state == IDLE) && disp_req && res_free;
    assign req_word = '{op: issue.op, src_a: issue.src_a, src_b: issue.src_b, tag: next_tag};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state           <= IDLE;
            disp_ack        <= 1'b0;
            alloc           <= 1'b0;
            alloc_dest      <= '0;
            alloc_reg_write <= 1'b0;
            alu_valid       <= 1'b0;
            mul_valid       <= 1'b0;
            div_valid       <= 1'b0;
            alu_req         <= '0;
            mul_req         <= '0;
            div_req         <= '0;
        end else begin
            alloc     <= 1'b0;                // Single-cycle pulses by default
            alu_valid <= 1'b0;
            mul_valid <= 1'b0;
            div_valid <= 1'b0;
            alu_req   <= '0;                  // Idle requests read as zero
            mul_req   <= '0;
            div_req   <= '0;
            case (state)
                IDLE: begin
                    if (accept) begin
                        disp_ack        <= 1'b1;
                        alloc           <= 1'b1;  // Claim tail slot
                        alloc_dest      <= issue.dest;
                        alloc_reg_write <= issue.reg_write;
                        if (is_mul) begin
                            mul_valid <= 1'b1;
                            mul_req   <= req_word;
                        end else if (is_div) begin
                            div_valid <= 1'b1;
                            div_req   <= req_word;
                        end else begin
                            alu_valid <= 1'b1;    // All logic and add/sub ops
                            alu_req   <= req_word;
                        end
                        state <= ACK;
                    end
                end
                ACK: begin
                    if (!disp_req) begin      // Producer saw ack and let go
                        disp_ack <= 1'b0;
                        state    <= WAIT_DROP;
                    end
                end
                // Guard cycle before the next accept
                WAIT_DROP: state <= IDLE;
                default:   state <= IDLE;
            endcase
        end
    end

    // Producer holds the instruction steady while req is up
    a_issue_stable: assert property (@(posedge clk) disable iff (rst)
        disp_req && $past(disp_req) |-> $stable(issue));

endmodule

`default_nettype wire

/* src/div_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module div_unit import rob_pkg::*; (
    input  wire       clk,
    input  wire       rst,
    input  wire       req_valid,
    input  unit_req_t req,
    output logic      busy,
    output wb_t       wb
);

    div_state_e           state;
    logic [DIV_CNT_W-1:0] cnt;                // Iteration index
    logic                 wb_valid_q;
    data_t                divisor_q;
    data_t                quo_q;              // Dividend shifts out, quotient shifts in
    data_t                rem_q;              // Partial remainder
    rob_tag_t             tag_q;              // Held until done
    logic [DATA_W:0]      rem_sh;
    logic                 fits;

    assign rem_sh = {rem_q, quo_q[DATA_W-1]};
    assign fits   = (rem_sh >= {1'b0, divisor_q});  // Zero divisor always fits so quotient is all ones
    assign busy   = (state != D_IDLE);
    assign wb     = '{valid: wb_valid_q, tag: tag_q, value: quo_q};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= D_IDLE;
            cnt        <= '0;
            wb_valid_q <= 1'b0;
        end else begin
            wb_valid_q <= 1'b0;
            case (state)
                D_IDLE: begin
                    if (req_valid) begin
                        cnt   <= '0;
                        state <= D_RUN;
                    end
                end
                D_RUN: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == DIV_CNT_W'(DATA_W - 1)) begin
                        state <= D_DONE;      // Last quotient bit this edge
                    end
                end
                D_DONE: begin
                    wb_valid_q <= 1'b1;       // Busy drops with result
                    state      <= D_IDLE;
                end
                default: state <= D_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == D_IDLE && req_valid) begin
            divisor_q <= req.src_b;
            quo_q     <= req.src_a;
            rem_q     <= '0;
            tag_q     <= req.tag;
        end else if (state == D_RUN) begin
            rem_q <= fits ? DATA_W'(rem_sh - {1'b0, divisor_q}) : rem_sh[DATA_W-1:0];
            quo_q <= {quo_q[DATA_W-2:0], fits};
        end
    end

    a_no_issue_busy: assert property (@(posedge clk) disable iff (rst)
        req_valid |-> !busy);

endmodule

`default_nettype wire

/* src/exec_backend.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_backend import rob_pkg::*; (
    input  wire     clk,
    input  wire     rst,
    input  wire     disp_req,
    input  issue_t  issue,
    output logic    disp_ack,
    output logic    commit_valid,
    output commit_t commit
);

    logic      rob_full;
    rob_tag_t  next_tag;
    logic      div_busy;
    logic      alloc;
    reg_idx_t  alloc_dest;
    logic      alloc_reg_write;
    unit_req_t alu_req, mul_req, div_req;
    logic      alu_valid, mul_valid, div_valid;
    wb_t       alu_wb, mul_wb, div_wb;        // Out-of-order results by tag

    dispatch_ctrl u_dispatch (
        .clk(clk), .rst(rst),
        .disp_req(disp_req), .issue(issue), .disp_ack(disp_ack),
        .rob_full(rob_full), .next_tag(next_tag), .div_busy(div_busy),
        .alloc(alloc), .alloc_dest(alloc_dest), .alloc_reg_write(alloc_reg_write),
        .alu_req(alu_req), .alu_valid(alu_valid),
        .mul_req(mul_req), .mul_valid(mul_valid),
        .div_req(div_req), .div_valid(div_valid)
    );

    reorder_buffer u_rob (
        .clk(clk), .rst(rst),
        .alloc(alloc), .alloc_dest(alloc_dest), .alloc_reg_write(alloc_reg_write),
        .next_tag(next_tag), .rob_full(rob_full),
        .alu_wb(alu_wb), .mul_wb(mul_wb), .div_wb(div_wb),
        .commit_valid(commit_valid), .commit(commit)
    );

    alu_unit u_alu (
        .clk(clk), .rst(rst), .req_valid(alu_valid), .req(alu_req), .wb(alu_wb)
    );

    mul_unit u_mul (
        .clk(clk), .rst(rst), .req_valid(mul_valid), .req(mul_req), .wb(mul_wb)
    );

    div_unit u_div (
        .clk(clk), .rst(rst), .req_valid(div_valid), .req(div_req),
        .busy(div_busy), .wb(div_wb)
    );

endmodule

`default_nettype wire

/* src/mul_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module mul_unit import rob_pkg::*; (
    input  wire       clk,
    input  wire       rst,
    input  wire       req_valid,
    input  unit_req_t req,
    output wb_t       wb
);

    logic [MUL_STAGES-1:0] vld_q;             // Valid chain, one bit per stage
    rob_tag_t              tag_q  [MUL_STAGES];
    data_t                 prod_q [MUL_STAGES];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[MUL_STAGES-2:0], req_valid};  // New op every cycle
        end
    end

    always_ff @(posedge clk) begin
        tag_q[0]  <= req.tag;
        prod_q[0] <= req.src_a * req.src_b;   // Low word of product only
        for (int s = 1; s < MUL_STAGES; s++) begin
            tag_q[s]  <= tag_q[s-1];
            prod_q[s] <= prod_q[s-1];
        end
    end

    assign wb = '{
        valid: vld_q[MUL_STAGES-1],
        tag:   tag_q[MUL_STAGES-1],
        value: prod_q[MUL_STAGES-1]
    };

endmodule

`default_nettype wire

/* src/reorder_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module reorder_buffer import rob_pkg::*; (
    input  wire      clk,
    input  wire      rst,
    input  wire      alloc,
    input  reg_idx_t alloc_dest,
    input  wire      alloc_reg_write,
    output rob_tag_t next_tag,
    output logic     rob_full,
    input  wb_t      alu_wb,
    input  wb_t      mul_wb,
    input  wb_t      div_wb,
    output logic     commit_valid,
    output commit_t  commit
);

    logic [ROB_DEPTH-1:0] busy_q;             // Slot holds a dispatched op
    logic [ROB_DEPTH-1:0] ready_q;            // Result has arrived
    logic [ROB_DEPTH-1:0] rw_q;
    reg_idx_t             dest_q  [ROB_DEPTH];
    data_t                value_q [ROB_DEPTH];
    rob_tag_t             head;               // Oldest op
    rob_tag_t             tail;               // Next free slot
    logic [TAG_W:0]       count;
    logic                 retire;
    wb_t                  wb_ports [NUM_WB];

    assign wb_ports[0] = alu_wb;
    assign wb_ports[1] = mul_wb;
    assign wb_ports[2] = div_wb;

    assign retire   = busy_q[head] && ready_q[head];  // In-order retirement only
    assign next_tag = tail;
    assign rob_full = (count == (TAG_W+1)'(ROB_DEPTH));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy_q       <= '0;
            ready_q      <= '0;
            head         <= '0;
            tail         <= '0;
            count        <= '0;
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= retire;           // Commit lags ready by a cycle
            if (retire) begin
                busy_q[head]  <= 1'b0;
                ready_q[head] <= 1'b0;
                head          <= head + 1'b1; // Pointers wrap at ROB_DEPTH
            end
            for (int p = 0; p < NUM_WB; p++) begin
                if (wb_ports[p].valid) begin
                    ready_q[wb_ports[p].tag] <= 1'b1;
                end
            end
            if (alloc) begin
                busy_q[tail]  <= 1'b1;
                ready_q[tail] <= 1'b0;
                tail          <= tail + 1'b1;
            end
            if (alloc && !retire) begin
                count <= count + 1'b1;
            end else if (!alloc && retire) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (retire) begin
            commit <= '{value: value_q[head], dest: dest_q[head], reg_write: rw_q[head]};
        end
        for (int p = 0; p < NUM_WB; p++) begin
            if (wb_ports[p].valid) begin
                value_q[wb_ports[p].tag] <= wb_ports[p].value;  // Out-of-order fill
            end
        end
        if (alloc) begin
            dest_q[tail] <= alloc_dest;
            rw_q[tail]   <= alloc_reg_write;
        end
    end

    a_no_alloc_full: assert property (@(posedge clk) disable iff (rst)
        alloc |-> !rob_full);

    for (genvar p = 0; p < NUM_WB; p++) begin : g_wb_chk
        // Each tag gets exactly one result while its slot is live
        a_wb_live: assert property (@(posedge clk) disable iff (rst)
            wb_ports[p].valid |-> busy_q[wb_ports[p].tag] && !ready_q[wb_ports[p].tag]);
    end

endmodule

`default_nettype wire

/* src/rob_pkg.sv */
`default_nettype none

package rob_pkg;

    localparam int DATA_W     = 32;              // Operand and result width
    localparam int REG_W      = 5;               // Architectural register index
    localparam int ROB_DEPTH  = 16;              // Reorder buffer slots
    localparam int TAG_W      = 4;               // log2 of ROB_DEPTH
    localparam int MUL_STAGES = 3;               // Multiplier pipeline depth
    localparam int NUM_WB     = 3;               // ALU, MUL, DIV write-back ports
    localparam int DIV_CNT_W  = $clog2(DATA_W);  // Divider iteration counter

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [REG_W-1:0]  reg_idx_t;
    typedef logic [TAG_W-1:0]  rob_tag_t;

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_MUL = 3'd5,
        OP_DIV = 3'd6
    } op_e;

    typedef enum logic [1:0] {IDLE, ACK, WAIT_DROP} disp_state_e;
    typedef enum logic [1:0] {D_IDLE, D_RUN, D_DONE} div_state_e;

    typedef struct packed {
        op_e      op;
        data_t    src_a;      // Operands already read
        data_t    src_b;
        reg_idx_t dest;
        logic     reg_write;
    } issue_t;

    typedef struct packed {
        op_e      op;
        data_t    src_a;
        data_t    src_b;
        rob_tag_t tag;        // Slot to write back into
    } unit_req_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        data_t    value;
    } wb_t;

    typedef struct packed {
        data_t    value;
        reg_idx_t dest;
        logic     reg_write;
    } commit_t;

endpackage

`default_nettype wire

/* test/backend_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module backend_tb import rob_pkg::*;;

    localparam int NUM_ROWS     = 40;
    localparam int NUM_FIXED    = 6;         // Corner rows at the top of the table
    localparam int DIV_RUN_START = 23;       // Start of the long divide run
    localparam int WATCHDOG_CYC = NUM_ROWS * 40 + 100;
    localparam int CLK_HALF     = 4;

    logic    clk;
    logic    rst;
    logic    disp_req;
    issue_t  issue;
    logic    disp_ack;
    logic    commit_valid;
    commit_t commit;

    issue_t  rows [NUM_ROWS];
    commit_t expect_q [$];                   // Reference commits in program order
    int      mismatch_cnt;
    int      other_cnt;
    int      commit_cnt;
    int      max_div_wait;
    int      waited;
    logic    prev_ack;

    exec_backend UUT (
        .clk(clk), .rst(rst),
        .disp_req(disp_req), .issue(issue), .disp_ack(disp_ack),
        .commit_valid(commit_valid), .commit(commit)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    function automatic issue_t make_row(input op_e op, input data_t a, input data_t b,
                                        input reg_idx_t dest, input logic rw);
        issue_t r;
        r.op        = op;
        r.src_a     = a;
        r.src_b     = b;
        r.dest      = dest;
        r.reg_write = rw;
        return r;
    endfunction

    // Result per opcode from the op definitions
    function automatic data_t expected_value(input issue_t ins);
        logic [2*DATA_W-1:0] wide;
        case (ins.op)
            OP_ADD: return ins.src_a + ins.src_b;
            OP_SUB: return ins.src_a - ins.src_b;
            OP_AND: return ins.src_a & ins.src_b;
            OP_OR:  return ins.src_a | ins.src_b;
            OP_XOR: return ins.src_a ^ ins.src_b;
            OP_MUL: begin
                wide = {{DATA_W{1'b0}}, ins.src_a} * {{DATA_W{1'b0}}, ins.src_b};
                return wide[DATA_W-1:0];      // Keep low word
            end
            OP_DIV: return (ins.src_b == '0) ? {DATA_W{1'b1}} : ins.src_a / ins.src_b;
            default: return '0;
        endcase
    endfunction

    task automatic check_commit(input commit_t got, input commit_t exp, input int idx);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("MISMATCH at %0t: commit %0d got value %h dest %0d rw %b, expected %h %0d %b",
                     $time, idx, got.value, got.dest, got.reg_write,
                     exp.value, exp.dest, exp.reg_write);
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            mismatch_cnt++;
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Four-phase req/ack driver that returns cycles spent waiting for ack
    task automatic drive_row(input issue_t ins, output int wait_cyc);
        wait_cyc = 0;
        @(negedge clk);
        issue    = ins;
        disp_req = 1'b1;
        @(negedge clk);
        while (!disp_ack) begin
            wait_cyc++;
            @(negedge clk);
        end
        disp_req = 1'b0;
        while (disp_ack) @(negedge clk);
    endtask

    // Outputs sampled mid-cycle well clear of both edges
    initial begin
        prev_ack = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            if (!rst) begin
                if (disp_ack && !prev_ack) check_level(disp_req, 1'b1, "disp_req at ack rise");
                if (!disp_ack && prev_ack) check_level(disp_req, 1'b0, "disp_req at ack fall");
                if (commit_valid) begin
                    if (expect_q.size() == 0) begin
                        other_cnt++;
                        $display("Error at %0t: commit arrived with no instruction left", $time);
                    end else begin
                        check_commit(commit, expect_q.pop_front(), commit_cnt);
                    end
                    commit_cnt++;
                end
            end
            prev_ack = disp_ack;
        end
    end

    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk);
        $display("Error: run did not finish within %0d clock cycles", WATCHDOG_CYC);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h76b2));
        rst          = 1'b1;
        disp_req     = 1'b0;
        issue        = '0;
        mismatch_cnt = 0;
        other_cnt    = 0;
        commit_cnt   = 0;
        max_div_wait = 0;

        rows[0] = make_row(OP_DIV, 32'd1234, 32'd0, 5'd1, 1'b1);          // Zero divisor
        rows[1] = make_row(OP_MUL, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 5'd2, 1'b1);
        rows[2] = make_row(OP_ADD, 32'h7FFF_FFFF, 32'd1, 5'd3, 1'b0);     // No reg write
        rows[3] = make_row(OP_SUB, 32'd0, 32'd1, 5'd4, 1'b1);
        rows[4] = make_row(OP_DIV, 32'd100, 32'd7, 5'd5, 1'b1);
        rows[5] = make_row(OP_XOR, 32'hA5A5_A5A5, 32'h0F0F_0F0F, 5'd6, 1'b0);
        // Slow divide followed by younger ops that finish first
        rows[NUM_FIXED] = make_row(OP_DIV, $urandom, ($urandom % 50) + 1, 5'd7, 1'b1);
        for (int i = NUM_FIXED + 1; i < DIV_RUN_START; i++) begin
            rows[i] = make_row(op_e'($urandom % 6), $urandom, $urandom,
                               reg_idx_t'($urandom), 1'($urandom));
        end
        for (int i = DIV_RUN_START; i < NUM_ROWS; i++) begin
            rows[i] = make_row(OP_DIV, $urandom, $urandom % 300,   // Zero now and then
                               reg_idx_t'($urandom), 1'($urandom));
        end
        foreach (rows[i]) begin
            expect_q.push_back(commit_t'{value: expected_value(rows[i]),
                                         dest: rows[i].dest, reg_write: rows[i].reg_write});
        end

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        repeat (5) begin                      // Quiet outputs before first request
            @(negedge clk);
            check_level(disp_ack, 1'b0, "disp_ack after reset");
            check_level(commit_valid, 1'b0, "commit_valid after reset");
        end

        for (int i = 0; i < NUM_ROWS; i++) begin
            drive_row(rows[i], waited);
            if (i > DIV_RUN_START && waited > max_div_wait) max_div_wait = waited;
        end

        while (commit_cnt < NUM_ROWS) @(negedge clk);
        repeat (40) @(negedge clk);           // Window for stray commits

        check_level(max_div_wait > 20, 1'b1, "divider back-pressure on ack");
        if (commit_cnt != NUM_ROWS) begin
            other_cnt++;
            $display("Error: %0d commits seen for %0d instructions", commit_cnt, NUM_ROWS);
        end
        if (expect_q.size() != 0) begin
            other_cnt++;
            $display("Error: %0d expected commits never arrived", expect_q.size());
        end

        $display("Done: %0d commits, %0d mismatches, %0d other errors",
                 commit_cnt, mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
